// ==== genesis_mbus.f ====
+incdir+rtl
rtl/genesis_mbus_pkg.sv
rtl/mbus_if.sv
rtl/work_ram.sv
rtl/mbus_decode.sv
rtl/mbus_execute.sv
rtl/mbus_result.sv
rtl/genesis_mbus.sv
test/tb_genesis_mbus.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the main bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f genesis_mbus.f \
	--top-module tb_genesis_mbus \
	--Mdir obj_dir -o tb_genesis_mbus
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_genesis_mbus
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit 1
fi

exit 0

// ==== test/tb_genesis_mbus.sv ====
// --------------------------------------------------
// Testbench for the 68000 main bus controller with
// random bus cycles, a ROM responder and a model
// --------------------------------------------------
`timescale 1ns/1ps

module tb_genesis_mbus import genesis_mbus_pkg::*; ();

	localparam int NUM_CYCLES = 400;
	localparam int TIMEOUT_CYCLES = 10000;
	// Capture at the 1st edge and DTACK seen low at the 5th
	localparam int DTACK_EDGES = 5;
	localparam int RAM_WORDS = 16;
	localparam logic [10:0] RAM_WINDOW = 11'h5A3;
	localparam mbus_addr_t ROM_SIZE = 23'h180000;

	logic       MCLK = 1'b0;
	logic       reset;
	logic       as_n;
	logic       rnw;
	logic       uds_n;
	logic       lds_n;
	mbus_addr_t addr;
	mbus_data_t wdata;
	mbus_data_t rdata;
	logic       dtack_n;
	mbus_addr_t rom_size;
	mbus_addr_t rom_addr;
	mbus_data_t rom_data = '0;
	logic       rom_req;
	logic       rom_ack = 1'b0;
	logic       z80_busak_n;
	logic       z80_busreq_n;
	logic       z80_reset_n;

	integer     seed = 32'he72c_06c3;
	int         cycles = 0;
	logic       rom_busy = 1'b0;
	logic [2:0] rom_delay = '0;
	mbus_addr_t cycle_addr = '0;

	// Reference model state
	mbus_data_t ram_m [0:RAM_WORDS-1];
	mbus_data_t open_bus_m;
	logic       busreq_m;
	logic       reset_m;

	genesis_mbus UUT (
		.MCLK         (MCLK),
		.reset        (reset),
		.as_n         (as_n),
		.rnw          (rnw),
		.uds_n        (uds_n),
		.lds_n        (lds_n),
		.addr         (addr),
		.wdata        (wdata),
		.rdata        (rdata),
		.dtack_n      (dtack_n),
		.rom_size     (rom_size),
		.rom_addr     (rom_addr),
		.rom_data     (rom_data),
		.rom_req      (rom_req),
		.rom_ack      (rom_ack),
		.z80_busak_n  (z80_busak_n),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n)
	);

	always #2 MCLK = ~MCLK;

	always @(posedge MCLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the bus cycles did not finish within %0d clocks", TIMEOUT_CYCLES);
			$display("Test failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// --------------------------------------------------
	// ROM responder with toggle request and acknowledge
	// --------------------------------------------------
	always @(posedge MCLK) begin
		if (reset) begin
			rom_ack <= 1'b0;
			rom_busy <= 1'b0;
		end else if (!rom_busy) begin
			if (rom_req != rom_ack) begin
				logic [31:0] rnd;
				rnd = $random(seed);
				check_addr("rom_addr", rom_addr, cycle_addr);
				rom_delay <= rnd[2:0];
				rom_busy <= 1'b1;
			end
		end else if (rom_delay == 3'd0) begin
			// Word contents follow from the address alone
			rom_data <= rom_addr[16:1] ^ 16'hA5A5;
			rom_ack <= rom_req;
			rom_busy <= 1'b0;
		end else begin
			rom_delay <= rom_delay - 3'd1;
		end
	end

	task automatic check_data(input string name, input mbus_data_t got, input mbus_data_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "Data mismatch");
		end
	endtask

	task automatic check_addr(input string name, input mbus_addr_t got, input mbus_addr_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "Address mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "Bit mismatch");
		end
	endtask

	// Address map of the 68000 side
	function automatic mbus_region_e region_of(input mbus_addr_t a);
		if (a[23:20] < 4'hA)
			return REGION_ROM;
		if (a[23:12] == 12'hA11 && a[7:1] == 7'h00)
			return REGION_CTRL;
		if (a[23:21] == 3'b111)
			return REGION_RAM;
		return REGION_NONE;
	endfunction

	// --------------------------------------------------
	// One 68000 bus cycle checked against the model
	// --------------------------------------------------
	task automatic run_cycle(input mbus_addr_t a, input logic r, input logic u_n,
			input logic l_n, input mbus_data_t d, input logic busak);
		mbus_region_e region;
		mbus_data_t   exp;
		mbus_data_t   got;
		logic [31:0]  rnd;
		logic [1:0]   hold;
		logic         fixed;
		int           edges;
		rnd = $random(seed);
		hold = rnd[1:0];
		region = region_of(a);
		fixed = !(region == REGION_ROM && r && a < ROM_SIZE);
		cycle_addr = a;
		as_n <= 1'b0;
		addr <= a;
		rnw <= r;
		uds_n <= u_n;
		lds_n <= l_n;
		wdata <= d;
		z80_busak_n <= busak;
		@(posedge MCLK);
		edges = 1;
		while (dtack_n !== 1'b0) begin
			@(posedge MCLK);
			edges++;
		end
		got = rdata;
		exp = open_bus_m;
		case (region)
			REGION_ROM: begin
				if (r && a < ROM_SIZE) begin
					exp = a[16:1] ^ 16'hA5A5;
					open_bus_m = exp;
				end else if (r) begin
					exp = '0;
				end
			end
			REGION_RAM: begin
				if (r) begin
					exp = ram_m[a[4:1]];
					open_bus_m = exp;
				end else begin
					if (!u_n)
						ram_m[a[4:1]][15:8] = d[15:8];
					if (!l_n)
						ram_m[a[4:1]][7:0] = d[7:0];
				end
			end
			REGION_CTRL: begin
				if (r && a[11:8] == 4'h1)
					exp[8] = busak;
				else if (r && a[11:8] == 4'h2)
					exp[8] = reset_m;
				if (!r && !u_n && a[11:8] == 4'h1)
					busreq_m = ~d[8];
				if (!r && !u_n && a[11:8] == 4'h2)
					reset_m = d[8];
			end
			default: ;
		endcase
		if (fixed && edges != DTACK_EDGES) begin
			$display("ERROR at %0t ns: dtack_n fell %0d edges after as_n, expected %0d",
				$time, edges, DTACK_EDGES);
			$display("Test failed");
			$fatal(1, "DTACK timing mismatch");
		end
		if (r)
			check_data("rdata", got, exp);
		check_bit("z80_busreq_n", z80_busreq_n, busreq_m);
		check_bit("z80_reset_n", z80_reset_n, reset_m);
		// DTACK holds while the CPU keeps the strobe low
		repeat (hold) begin
			@(posedge MCLK);
			check_bit("dtack_n", dtack_n, 1'b0);
			check_data("rdata", rdata, got);
		end
		as_n <= 1'b1;
		uds_n <= 1'b1;
		lds_n <= 1'b1;
		@(posedge MCLK);
		check_bit("dtack_n", dtack_n, 1'b0);
		@(posedge MCLK);
		check_bit("dtack_n", dtack_n, 1'b1);
	endtask

	initial begin
		logic [31:0] rnd;
		logic [31:0] rnd2;
		logic [7:0]  nib;
		mbus_addr_t  a;
		logic        r;
		reset = 1'b1;
		as_n = 1'b1;
		rnw = 1'b1;
		uds_n = 1'b1;
		lds_n = 1'b1;
		addr = '0;
		wdata = '0;
		rom_size = ROM_SIZE;
		z80_busak_n = 1'b1;
		open_bus_m = 16'h4E71;
		busreq_m = 1'b1;
		reset_m = 1'b0;
		repeat (2) @(posedge MCLK);
		reset <= 1'b0;
		@(posedge MCLK);
		check_bit("dtack_n", dtack_n, 1'b1);
		check_bit("rom_req", rom_req, 1'b0);
		check_bit("z80_busreq_n", z80_busreq_n, 1'b1);
		check_bit("z80_reset_n", z80_reset_n, 1'b0);

		// Fill the RAM window through random mirrors
		for (int n = 0; n < RAM_WORDS; n++) begin
			rnd = $random(seed);
			a = {3'b111, rnd[8:4], RAM_WINDOW, n[3:0]};
			run_cycle(a, 1'b0, 1'b0, 1'b0, rnd[31:16], 1'b1);
		end

		for (int n = 0; n < NUM_CYCLES; n++) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			r = rnd[3];
			case (rnd[2:0])
				3'd0, 3'd1: begin
					a = rnd2[22:0];
					nib = rnd2[31:24] % 8'd10;
					a[23:20] = nib[3:0];
				end
				3'd5, 3'd7: a = {12'hA11, 2'b00, rnd2[1:0], 7'h00};
				3'd6: begin
					a = rnd2[22:0];
					a[23:20] = 4'hA + {2'b00, rnd2[24:23]};
				end
				default: a = {3'b111, rnd2[8:4], RAM_WINDOW, rnd2[3:0]};
			endcase
			if (r)
				run_cycle(a, 1'b1, 1'b0, 1'b0, rnd[31:16], rnd[6]);
			else
				run_cycle(a, 1'b0, rnd[5:4] == 2'd2, rnd[5:4] == 2'd1, rnd[31:16], rnd[6]);
			if (rnd[7])
				@(posedge MCLK);
		end

		$display("Test passed");
		$finish;
	end

endmodule

// ==== rtl/genesis_mbus.sv ====
// --------------------------------------------------
// 68000 main bus controller top level
// --------------------------------------------------
`timescale 1ns/1ps

module genesis_mbus import genesis_mbus_pkg::*; (
	input  logic       MCLK,
	input  logic       reset,
	input  logic       as_n,
	input  logic       rnw,
	input  logic       uds_n,
	input  logic       lds_n,
	input  mbus_addr_t addr,
	input  mbus_data_t wdata,
	output mbus_data_t rdata,
	output logic       dtack_n,
	input  mbus_addr_t rom_size,
	output mbus_addr_t rom_addr,
	input  mbus_data_t rom_data,
	output logic       rom_req,
	input  logic       rom_ack,
	input  logic       z80_busak_n,
	output logic       z80_busreq_n,
	output logic       z80_reset_n
);

	mbus_if bus_if ();

	mbus_decode u_decode (
		.MCLK     (MCLK),
		.reset    (reset),
		.as_n     (as_n),
		.rnw      (rnw),
		.uds_n    (uds_n),
		.lds_n    (lds_n),
		.addr     (addr),
		.wdata    (wdata),
		.rom_size (rom_size),
		.bus      (bus_if.decode)
	);

	mbus_execute u_execute (
		.MCLK         (MCLK),
		.reset        (reset),
		.rom_size     (rom_size),
		.rom_addr     (rom_addr),
		.rom_data     (rom_data),
		.rom_req      (rom_req),
		.rom_ack      (rom_ack),
		.z80_busak_n  (z80_busak_n),
		.z80_busreq_n (z80_busreq_n),
		.z80_reset_n  (z80_reset_n),
		.bus          (bus_if.execute)
	);

	mbus_result u_result (
		.MCLK    (MCLK),
		.reset   (reset),
		.as_n    (as_n),
		.rdata   (rdata),
		.dtack_n (dtack_n),
		.bus     (bus_if.result)
	);

endmodule

// ==== rtl/mbus_result.sv ====
// --------------------------------------------------
// Read word forming, open-bus register and DTACK
// --------------------------------------------------
`timescale 1ns/1ps
`include "genesis_mbus_config.svh"

module mbus_result import genesis_mbus_pkg::*; (
	input  logic       MCLK,
	input  logic       reset,
	input  logic       as_n,
	output mbus_data_t rdata,
	output logic       dtack_n,
	mbus_if.result     bus
);

	mbus_data_t open_bus;
	mbus_data_t ctrl_word;

	// Control reads only own a single bit of the word
	always_comb begin
		ctrl_word = open_bus;
		ctrl_word[`CTRL_FLAG_BIT] = bus.flag;
	end

	always_ff @(posedge MCLK) begin
		if (bus.done) begin
			case (bus.kind)
				KIND_DATA: rdata <= bus.data;
				KIND_ZERO: rdata <= '0;
				KIND_OPEN: rdata <= open_bus;
				KIND_CTRL: rdata <= ctrl_word;
				default: rdata <= open_bus;
			endcase
		end
	end

	// --------------------------------------------------
	// DTACK and cycle end
	// --------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			dtack_n <= 1'b1;
			bus.bus_free <= 1'b0;
			open_bus <= `OPEN_BUS_RESET;
		end else begin
			bus.bus_free <= 1'b0;
			if (bus.done) begin
				dtack_n <= 1'b0;
				if (bus.kind == KIND_DATA)
					open_bus <= bus.data;
			end else if (!dtack_n && as_n) begin
				// CPU has let go of the bus
				dtack_n <= 1'b1;
				bus.bus_free <= 1'b1;
			end
		end
	end

	// Execute only finishes one access per 68000 cycle
	assert property (@(posedge MCLK) disable iff (reset)
		bus.done |-> dtack_n);

endmodule

// ==== rtl/mbus_execute.sv ====
// --------------------------------------------------
// Bus access on ROM, work RAM and the two Z80
// control registers
// --------------------------------------------------
`timescale 1ns/1ps
`include "genesis_mbus_config.svh"

module mbus_execute import genesis_mbus_pkg::*; (
	input  logic       MCLK,
	input  logic       reset,
	input  mbus_addr_t rom_size,
	output mbus_addr_t rom_addr,
	input  mbus_data_t rom_data,
	output logic       rom_req,
	input  logic       rom_ack,
	input  logic       z80_busak_n,
	output logic       z80_busreq_n,
	output logic       z80_reset_n,
	mbus_if.execute    bus
);

	typedef enum logic [1:0] {ST_IDLE, ST_RAM, ST_ROM} state_e;

	state_e     state;
	mbus_data_t ram_rdata;
	mbus_data_t rom_q;
	mbus_kind_e kind_d;
	logic       flag_d;
	logic       rom_hit;
	logic       ram_we;
	logic       ctrl_we;
	logic       rom_done;
	logic [3:0] ctrl_sel;

	assign rom_hit = bus.addr < rom_size;
	assign ctrl_sel = bus.addr[11:8];
	assign ram_we = bus.req_valid && bus.region == REGION_RAM && !bus.rnw;
	// Control registers only listen to the upper byte
	assign ctrl_we = bus.req_valid && bus.region == REGION_CTRL && !bus.rnw && !bus.uds_n;
	assign rom_done = rom_req == rom_ack;

	work_ram u_work_ram (
		.MCLK  (MCLK),
		.addr  (bus.addr[`RAM_ADDR_W:1]),
		.wdata (bus.wdata),
		.we_hi (ram_we && !bus.uds_n),
		.we_lo (ram_we && !bus.lds_n),
		.rdata (ram_rdata)
	);

	assign rom_addr = bus.addr;
	// RAM word is valid in the cycle after the request
	assign bus.data = (state == ST_RAM) ? ram_rdata : rom_q;

	// --------------------------------------------------
	// Result kind per target
	// --------------------------------------------------
	always_comb begin
		kind_d = KIND_OPEN;
		flag_d = 1'b0;
		case (bus.region)
			REGION_ROM: if (bus.rnw) kind_d = rom_hit ? KIND_DATA : KIND_ZERO;
			REGION_RAM: if (bus.rnw) kind_d = KIND_DATA;
			REGION_CTRL: begin
				if (bus.rnw && ctrl_sel == `CTRL_BUSREQ_SEL) begin
					kind_d = KIND_CTRL;
					flag_d = z80_busak_n;
				end else if (bus.rnw && ctrl_sel == `CTRL_RESET_SEL) begin
					kind_d = KIND_CTRL;
					flag_d = z80_reset_n;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge MCLK) begin
		if (state == ST_IDLE && bus.req_valid) begin
			bus.kind <= kind_d;
			bus.flag <= flag_d;
		end
		if (state == ST_ROM && rom_done)
			rom_q <= rom_data;
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= ST_IDLE;
			rom_req <= 1'b0;
			bus.done <= 1'b0;
		end else begin
			bus.done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (bus.req_valid) begin
						if (bus.region == REGION_ROM && bus.rnw && rom_hit) begin
							rom_req <= ~rom_ack;
							state <= ST_ROM;
						end else begin
							bus.done <= 1'b1;
							if (bus.region == REGION_RAM)
								state <= ST_RAM;
						end
					end
				end
				ST_RAM: state <= ST_IDLE;
				ST_ROM: begin
					if (rom_done) begin
						bus.done <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Z80 bus request and reset lines
	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq_n <= 1'b1;
			z80_reset_n <= 1'b0;
		end else if (ctrl_we) begin
			if (ctrl_sel == `CTRL_BUSREQ_SEL)
				z80_busreq_n <= ~bus.wdata[`CTRL_FLAG_BIT];
			if (ctrl_sel == `CTRL_RESET_SEL)
				z80_reset_n <= bus.wdata[`CTRL_FLAG_BIT];
		end
	end

	// A new ROM request is only started between accesses
	assert property (@(posedge MCLK) disable iff (reset)
		(rom_req != $past(rom_req)) |-> ($past(state) == ST_IDLE));

endmodule

// ==== rtl/mbus_decode.sv ====
// --------------------------------------------------
// 68000 cycle capture and address region decode
// --------------------------------------------------
`timescale 1ns/1ps
`include "genesis_mbus_config.svh"

module mbus_decode import genesis_mbus_pkg::*; (
	input  logic       MCLK,
	input  logic       reset,
	input  logic       as_n,
	input  logic       rnw,
	input  logic       uds_n,
	input  logic       lds_n,
	input  mbus_addr_t addr,
	input  mbus_data_t wdata,
	input  mbus_addr_t rom_size,
	mbus_if.decode     bus
);

	logic         pending;
	logic         busy;
	logic         capture;
	mbus_region_e region_d;

	// Captured cycle, held until the next capture
	mbus_addr_t addr_q;
	mbus_data_t wdata_q;
	logic       rnw_q;
	logic       uds_n_q;
	logic       lds_n_q;

	// Idle means nothing pending and the last cycle has ended
	assign capture = !as_n && !pending && (!busy || bus.bus_free);

	always_ff @(posedge MCLK) begin
		if (capture) begin
			addr_q <= addr;
			wdata_q <= wdata;
			rnw_q <= rnw;
			uds_n_q <= uds_n;
			lds_n_q <= lds_n;
		end
	end

	// --------------------------------------------------
	// Region decode
	// --------------------------------------------------
	always_comb begin
		if (addr_q[23:20] < `ROM_TOP_NIBBLE)
			region_d = REGION_ROM;
		else if (addr_q[23:12] == `CTRL_PAGE && addr_q[7:1] == '0)
			region_d = REGION_CTRL;
		else if (&addr_q[23:21])
			region_d = REGION_RAM;
		else
			region_d = REGION_NONE;
	end

	always_ff @(posedge MCLK) begin
		if (pending)
			bus.region <= region_d;
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			pending <= 1'b0;
			busy <= 1'b0;
			bus.req_valid <= 1'b0;
		end else begin
			pending <= capture;
			bus.req_valid <= pending;
			if (pending)
				busy <= 1'b1;
			else if (bus.bus_free)
				busy <= 1'b0;
		end
	end

	assign bus.addr = addr_q;
	assign bus.wdata = wdata_q;
	assign bus.rnw = rnw_q;
	assign bus.uds_n = uds_n_q;
	assign bus.lds_n = lds_n_q;

	// One request per 68000 cycle
	assert property (@(posedge MCLK) disable iff (reset)
		bus.req_valid |-> !$past(busy));

	// Execute compares against the ROM size while a cycle is open
	assert property (@(posedge MCLK) disable iff (reset)
		busy |-> $stable(rom_size));

endmodule

// ==== rtl/work_ram.sv ====
// --------------------------------------------------
// 64 KB work RAM, 32K words with upper and lower
// byte write enables
// --------------------------------------------------
`timescale 1ns/1ps
`include "genesis_mbus_config.svh"

module work_ram import genesis_mbus_pkg::*; (
	input  logic                   MCLK,
	input  logic [`RAM_ADDR_W-1:0] addr,
	input  mbus_data_t             wdata,
	input  logic                   we_hi,
	input  logic                   we_lo,
	output mbus_data_t             rdata
);

	localparam int DEPTH = 2 ** `RAM_ADDR_W;
	localparam int HALF = `MBUS_DATA_W / 2;

	mbus_data_t mem [0:DEPTH-1];

	// Upper lane is the even byte on the 68000 bus
	always_ff @(posedge MCLK) begin
		if (we_hi)
			mem[addr][`MBUS_DATA_W-1:HALF] <= wdata[`MBUS_DATA_W-1:HALF];
		if (we_lo)
			mem[addr][HALF-1:0] <= wdata[HALF-1:0];
	end

	// Registered read, old contents on a same-cycle write
	always_ff @(posedge MCLK) begin
		rdata <= mem[addr];
	end

endmodule

// ==== rtl/mbus_if.sv ====
// --------------------------------------------------
// Request and completion signals between the
// decode, execute and result stages
// --------------------------------------------------
`timescale 1ns/1ps

interface mbus_if import genesis_mbus_pkg::*; ();

	// Request group
	logic         req_valid;
	mbus_region_e region;
	mbus_addr_t   addr;
	mbus_data_t   wdata;
	logic         rnw;
	logic         uds_n;
	logic         lds_n;

	// Completion group
	logic       done;
	mbus_kind_e kind;
	mbus_data_t data;
	logic       flag;

	// End of the 68000 cycle, lets decode capture again
	logic bus_free;

	modport decode (
		output req_valid, region, addr, wdata, rnw, uds_n, lds_n,
		input  bus_free
	);

	modport execute (
		input  req_valid, region, addr, wdata, rnw, uds_n, lds_n,
		output done, kind, data, flag
	);

	modport result (
		input  done, kind, data, flag,
		output bus_free
	);

endinterface

// ==== rtl/genesis_mbus_pkg.sv ====
// --------------------------------------------------
// Bus types, target regions and result kinds
// shared by the main bus stages
// --------------------------------------------------
`include "genesis_mbus_config.svh"

package genesis_mbus_pkg;

	// Word address, bit n is CPU address line An
	typedef logic [`MBUS_ADDR_W:1] mbus_addr_t;

	typedef logic [`MBUS_DATA_W-1:0] mbus_data_t;

	// Target picked by the address decoder
	typedef enum logic [1:0] {
		REGION_ROM,
		REGION_RAM,
		REGION_CTRL,
		REGION_NONE
	} mbus_region_e;

	// How the read word is formed at completion
	typedef enum logic [1:0] {
		// Returned data, also becomes the open-bus value
		KIND_DATA,
		KIND_ZERO,
		KIND_OPEN,
		// Open-bus value with the flag bit patched in
		KIND_CTRL
	} mbus_kind_e;

endpackage

// ==== rtl/genesis_mbus_config.svh ====
// --------------------------------------------------
// Widths, region address codes and reset values
// for the 68000 main bus controller
// --------------------------------------------------
`ifndef GENESIS_MBUS_CONFIG_SVH
`define GENESIS_MBUS_CONFIG_SVH

// Bus widths, word address covers A23..A1
`define MBUS_ADDR_W 23
`define MBUS_DATA_W 16
`define RAM_ADDR_W 15

// Value seen on an undriven bus after reset (NOP opcode)
`define OPEN_BUS_RESET 16'h4E71

// Region codes
`define ROM_TOP_NIBBLE 4'hA
`define CTRL_PAGE 12'hA11
`define CTRL_BUSREQ_SEL 4'h1
`define CTRL_RESET_SEL 4'h2
`define CTRL_FLAG_BIT 8

`endif
